// ==== src/mulTypesPkg.sv ====
package mulTypesPkg;

    localparam int operandWidth = 32;
    localparam int productWidth = 64;
    localparam int extWidth     = 34;  // 33-bit extension plus one zero below

    // one input operand
    typedef logic [operandWidth-1:0] operand_t;

    // partial products, sum/carry vectors and the result
    typedef logic [productWidth-1:0] product_t;

    // padded multiplier for group slicing
    typedef logic [extWidth-1:0] extOperand_t;

    // stage 1 request
    typedef struct packed {
        operand_t opA;       // multiplicand
        operand_t opB;       // multiplier
        logic     isSigned;  // both operands two's complement
    } mulReq_t;

    // stage 2 reducer result, redundant form
    typedef struct packed {
        product_t sumVec;
        product_t carryVec;
    } csVec_t;

endpackage

// ==== src/boothPkg.sv ====
package boothPkg;

    localparam int numGroups  = 17;  // covers the 34-bit padded multiplier
    localparam int groupShift = 2;   // radix-4

    // {b[2i+1], b[2i], b[2i-1]}
    typedef logic [2:0] boothGroup_t;

    typedef logic [4:0] groupIdx_t;

    // group codes and the digit each recodes to
    localparam boothGroup_t grpZeroLo    = 3'b000;  // 0
    localparam boothGroup_t grpPlusOneA  = 3'b001;  // +1
    localparam boothGroup_t grpPlusOneB  = 3'b010;  // +1
    localparam boothGroup_t grpPlusTwo   = 3'b011;  // +2
    localparam boothGroup_t grpMinusTwo  = 3'b100;  // -2
    localparam boothGroup_t grpMinusOneA = 3'b101;  // -1
    localparam boothGroup_t grpMinusOneB = 3'b110;  // -1
    localparam boothGroup_t grpZeroHi    = 3'b111;  // 0

endpackage

// ==== src/boothEncoder.sv ====
`timescale 1ns/1ps

module boothEncoder (
    input  boothPkg::boothGroup_t              grp,    // three multiplier bits
    input  boothPkg::groupIdx_t                gid,    // group position
    input  logic [mulTypesPkg::operandWidth:0] mcand,  // already extended by one bit
    output mulTypesPkg::product_t              pp
);

    logic                  isZero;
    logic                  isDouble;
    logic                  isNeg;
    logic [5:0]            shiftAmt;
    mulTypesPkg::product_t mcandExt;
    mulTypesPkg::product_t magnitude;
    mulTypesPkg::product_t shifted;

    // digit recoding
    always_comb begin
        isZero   = 1'b0;
        isDouble = 1'b0;
        isNeg    = 1'b0;
        case (grp)
            boothPkg::grpZeroLo,
            boothPkg::grpZeroHi: begin
                isZero = 1'b1;
            end
            boothPkg::grpPlusOneA,
            boothPkg::grpPlusOneB: begin
                isZero = 1'b0;
            end
            boothPkg::grpPlusTwo: begin
                isDouble = 1'b1;
            end
            boothPkg::grpMinusTwo: begin
                isDouble = 1'b1;
                isNeg    = 1'b1;
            end
            boothPkg::grpMinusOneA,
            boothPkg::grpMinusOneB: begin
                isNeg = 1'b1;
            end
            default: begin
                isZero = 1'b1;
            end
        endcase
    end

    assign mcandExt = {
        {(mulTypesPkg::productWidth - mulTypesPkg::operandWidth - 1)
            {mcand[mulTypesPkg::operandWidth]}},
        mcand
    };  // sign fill to 64 bits

    assign magnitude = isDouble ? (mcandExt << 1) : mcandExt;

    // weight of group i is 4^i
    assign shiftAmt = 6'(gid * boothPkg::groupShift);
    assign shifted  = magnitude << shiftAmt;

    // two's complement negate, wraps mod 2^64
    assign pp = isZero ? '0 :
                isNeg  ? (~shifted + mulTypesPkg::product_t'(1)) :
                         shifted;

endmodule

// ==== src/csaReduce.sv ====
`timescale 1ns/1ps

module csaReduce (
    input  mulTypesPkg::product_t [boothPkg::numGroups-1:0] pps,
    output mulTypesPkg::csVec_t                             cs
);

    // one entry per compressor row, numGroups-2 rows in the chain
    wire mulTypesPkg::product_t rowSum   [boothPkg::numGroups-2];
    wire mulTypesPkg::product_t rowCarry [boothPkg::numGroups-2];

    generate
        for (genvar r = 0; r < boothPkg::numGroups - 2; r++) begin : gRow
            mulTypesPkg::product_t x;
            mulTypesPkg::product_t y;
            mulTypesPkg::product_t z;
            mulTypesPkg::product_t maj;

            if (r == 0) begin : gFirst
                // first row takes three partial products
                assign x = pps[0];
                assign y = pps[1];
            end else begin : gFold
                assign x = rowSum[r-1];    // previous sum
                assign y = rowCarry[r-1];  // previous carry, already weighted
            end

            assign z = pps[r+2];

            // per-bit full adder
            assign maj         = (x & y) | (x & z) | (y & z);
            assign rowSum[r]   = x ^ y ^ z;
            assign rowCarry[r] = {maj[mulTypesPkg::productWidth-2:0], 1'b0};  // msb drops
        end
    endgenerate

    assign cs = '{
        sumVec:   rowSum[boothPkg::numGroups-3],
        carryVec: rowCarry[boothPkg::numGroups-3]
    };

endmodule

// ==== src/finalAdder.sv ====
`timescale 1ns/1ps

module finalAdder (
    input  mulTypesPkg::product_t a,
    input  mulTypesPkg::product_t b,
    output mulTypesPkg::product_t sum
);

    wire mulTypesPkg::product_t                   bitG;
    wire mulTypesPkg::product_t                   bitP;
    wire mulTypesPkg::product_t                   bitCarry;  // carry into each bit
    wire [mulTypesPkg::productWidth/4-1:0]        grpG;
    wire [mulTypesPkg::productWidth/4-1:0]        grpP;
    wire [mulTypesPkg::productWidth/4-1:0]        grpCarry;  // carry into each 4-bit group
    wire [2:0]                                    blkG;      // top block needs none
    wire [2:0]                                    blkP;
    wire [3:0]                                    blkCarry;  // carry into each 16-bit block

    // carries into the four positions of a lookahead cell
    function automatic logic [3:0] lookahead4(
        input logic [3:0] g,
        input logic [3:0] p,
        input logic       cin
    );
        logic [3:0] c;
        c[0] = cin;
        c[1] = g[0] | (p[0] & cin);
        c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
        c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
        return c;
    endfunction

    function automatic logic groupGen(
        input logic [3:0] g,
        input logic [3:0] p
    );
        return g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
    endfunction

    assign bitG = a & b;
    assign bitP = a ^ b;

    generate
        for (genvar k = 0; k < mulTypesPkg::productWidth / 4; k++) begin : gGroup
            assign grpG[k] = groupGen(bitG[4*k+3 -: 4], bitP[4*k+3 -: 4]);
            assign grpP[k] = &bitP[4*k+3 -: 4];
            assign bitCarry[4*k+3 -: 4] = lookahead4(bitG[4*k+3 -: 4], bitP[4*k+3 -: 4],
                                                     grpCarry[k]);
        end

        // second level, four groups per block
        for (genvar j = 0; j < 4; j++) begin : gBlock
            assign grpCarry[4*j+3 -: 4] = lookahead4(grpG[4*j+3 -: 4], grpP[4*j+3 -: 4],
                                                     blkCarry[j]);
        end

        // blocks chained, carry out of the top block dropped
        for (genvar j = 0; j < 3; j++) begin : gChain
            assign blkG[j]       = groupGen(grpG[4*j+3 -: 4], grpP[4*j+3 -: 4]);
            assign blkP[j]       = &grpP[4*j+3 -: 4];
            assign blkCarry[j+1] = blkG[j] | (blkP[j] & blkCarry[j]);
        end
    endgenerate

    assign blkCarry[0] = 1'b0;

    assign sum = bitP ^ bitCarry;

endmodule

// ==== src/boothMulPipe.sv ====
`timescale 1ns/1ps

module boothMulPipe (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid,
    input  mulTypesPkg::operand_t opA,
    input  mulTypesPkg::operand_t opB,
    input  logic                  isSigned,
    output logic                  outValid,
    output mulTypesPkg::product_t product
);

    mulTypesPkg::mulReq_t                        s1Req;
    logic                                        s1Valid;
    logic [mulTypesPkg::operandWidth:0]          mcand;
    mulTypesPkg::extOperand_t                    mplier;
    wire mulTypesPkg::product_t [boothPkg::numGroups-1:0] pps;
    mulTypesPkg::csVec_t                         csNext;
    mulTypesPkg::csVec_t                         s2Cs;
    logic                                        s2Valid;
    mulTypesPkg::product_t                       addSum;

    // valid chain, the only reset state
    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid  <= 1'b0;
            s2Valid  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            s1Valid  <= inValid;
            s2Valid  <= s1Valid;
            outValid <= s2Valid;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (inValid) begin
            s1Req.opA      <= opA;
            s1Req.opB      <= opB;
            s1Req.isSigned <= isSigned;
        end
        if (s1Valid) begin
            s2Cs <= csNext;
        end
        if (s2Valid) begin
            product <= addSum;
        end
    end

    // one extra bit, sign or zero
    assign mcand = {s1Req.isSigned & s1Req.opA[mulTypesPkg::operandWidth-1], s1Req.opA};

    assign mplier = {s1Req.isSigned & s1Req.opB[mulTypesPkg::operandWidth-1], s1Req.opB, 1'b0};

    generate
        for (genvar i = 0; i < boothPkg::numGroups; i++) begin : gEnc
            boothPkg::boothGroup_t grp;

            if (i == boothPkg::numGroups - 1) begin : gTop
                // top group reaches one bit past the padding, repeat the extension bit
                assign grp = {mplier[mulTypesPkg::extWidth-1],
                              mplier[mulTypesPkg::extWidth-1 -: 2]};
            end else begin : gMid
                assign grp = mplier[boothPkg::groupShift*i+2 -: 3];
            end

            boothEncoder encoder (
                .grp  (grp),
                .gid  (boothPkg::groupIdx_t'(i)),
                .mcand(mcand),
                .pp   (pps[i])
            );
        end
    endgenerate

    csaReduce reducer (
        .pps(pps),
        .cs (csNext)
    );

    finalAdder adder (
        .a  (s2Cs.sumVec),
        .b  (s2Cs.carryVec),
        .sum(addSum)
    );

    inValidKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(inValid))
        else $error("inValid is X outside reset");

    productKnown: assert property (@(posedge clk) disable iff (rst)
        outValid |-> !$isunknown(product))
        else $error("product has X bits while outValid is high");

    // stage 2 mirrors stage 1 one cycle later
    stage2Follows: assert property (@(posedge clk) disable iff (rst)
        s1Valid |=> s2Valid)
        else $error("stage 1 valid was not passed to stage 2");

endmodule

// ==== tests/tbBoothMul.sv ====
`timescale 1ns/1ps

module tbBoothMul;

    localparam int clkHalf     = 2;     // 4 ns period
    localparam int latency     = 3;
    localparam int numCorners  = 7;
    localparam int streamOps   = 300;
    localparam int drainLimit  = 10;
    // ~100 corner ops, 300 back-to-back, up to 1200 gapped, reset and drains
    localparam int maxCycles   = 3000;

    typedef struct packed {
        mulTypesPkg::operand_t a;
        mulTypesPkg::operand_t b;
        logic                  sgn;
        mulTypesPkg::product_t expected;
        logic [31:0]           issueCycle;  // cycle the operation is driven in
    } scoreEntry_t;

    logic                  clk;
    logic                  rst;
    logic                  inValid;
    mulTypesPkg::operand_t opA;
    mulTypesPkg::operand_t opB;
    logic                  isSigned;
    logic                  outValid;
    mulTypesPkg::product_t product;

    scoreEntry_t scoreQ[$];
    int          cycleCount;
    int          valueErrors;
    int          latencyErrors;
    int          protocolErrors;

    boothMulPipe i_boothMulPipe (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .opA     (opA),
        .opB     (opB),
        .isSigned(isSigned),
        .outValid(outValid),
        .product (product)
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: run stopped after %0d cycles", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // full-width product of the extended operands, mod 2^64
    function automatic mulTypesPkg::product_t refProduct(
        input mulTypesPkg::operand_t a,
        input mulTypesPkg::operand_t b,
        input logic                  sgn
    );
        mulTypesPkg::product_t xa;
        mulTypesPkg::product_t xb;
        xa = sgn ? {{32{a[31]}}, a} : {32'b0, a};
        xb = sgn ? {{32{b[31]}}, b} : {32'b0, b};
        return xa * xb;
    endfunction

    function automatic mulTypesPkg::operand_t cornerValue(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hFFFF_FFFF;
            3:       return 32'h8000_0000;  // most negative
            4:       return 32'h7FFF_FFFF;  // most positive
            5:       return 32'hAAAA_AAAA;
            default: return 32'h5555_5555;
        endcase
    endfunction

    // scoreboard monitor, sampled mid-cycle
    always @(negedge clk) begin
        scoreEntry_t entry;
        if (outValid === 1'b1) begin
            if (scoreQ.size() == 0) begin
                protocolErrors++;
                $display("outValid went high at %0t with no operation outstanding", $time);
            end else begin
                entry = scoreQ.pop_front();
                if (product !== entry.expected) begin
                    valueErrors++;
                    $display("** Error at %0t: opA=%h opB=%h signed=%0b expected %h got %h",
                             $time, entry.a, entry.b, entry.sgn, entry.expected, product);
                end
                if (cycleCount != entry.issueCycle + latency) begin
                    latencyErrors++;
                    $display("** Error at %0t: opA=%h opB=%h latency expected %0d got %0d",
                             $time, entry.a, entry.b, latency,
                             cycleCount - entry.issueCycle);
                end
            end
        end
    end

    task automatic issueOp(
        input mulTypesPkg::operand_t a,
        input mulTypesPkg::operand_t b,
        input logic                  sgn
    );
        scoreEntry_t entry;
        @(posedge clk);
        #1;
        inValid  = 1'b1;
        opA      = a;
        opB      = b;
        isSigned = sgn;
        entry.a          = a;
        entry.b          = b;
        entry.sgn        = sgn;
        entry.expected   = refProduct(a, b, sgn);
        entry.issueCycle = cycleCount;  // result due three cycles on
        scoreQ.push_back(entry);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (scoreQ.size() != 0 && waited < drainLimit) begin
            @(posedge clk);
            waited++;
        end
        if (scoreQ.size() != 0) begin
            protocolErrors++;
            $display("results missing: %0d operations never came out", scoreQ.size());
            scoreQ.delete();
        end
    endtask

    task automatic resetState();
        rst     = 1'b1;
        inValid = 1'b0;
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #1;
            if (i == 3) begin
                rst = 1'b0;  // held through 4 edges
            end
            @(negedge clk);
            if (outValid !== 1'b0) begin
                valueErrors++;
                $display("** Error at %0t: outValid=%b during or just after reset",
                         $time, outValid);
            end
        end
    endtask

    task automatic runCorners(input logic sgn);
        for (int i = 0; i < numCorners; i++) begin
            for (int j = 0; j < numCorners; j++) begin
                issueOp(cornerValue(i), cornerValue(j), sgn);
            end
        end
        idleCycles(1);
        waitDrain();
    endtask

    task automatic signedCorners();
        runCorners(1'b1);
    endtask

    task automatic unsignedCorners();
        runCorners(1'b0);
    endtask

    task automatic backToBack();
        for (int i = 0; i < streamOps; i++) begin
            issueOp(mulTypesPkg::operand_t'($urandom()), mulTypesPkg::operand_t'($urandom()),
                    1'($urandom()));
        end
        idleCycles(1);
        waitDrain();
    endtask

    task automatic gappedStream();
        int gap;
        for (int i = 0; i < streamOps; i++) begin
            issueOp(mulTypesPkg::operand_t'($urandom()), mulTypesPkg::operand_t'($urandom()),
                    1'($urandom()));
            gap = $urandom() % 4;
            idleCycles(gap);
        end
        idleCycles(1);
        waitDrain();
    endtask

    task automatic midStreamReset();
        for (int i = 0; i < 2; i++) begin
            issueOp(mulTypesPkg::operand_t'($urandom()), mulTypesPkg::operand_t'($urandom()),
                    1'($urandom()));
        end
        @(posedge clk);
        #1;
        inValid = 1'b0;
        rst     = 1'b1;
        scoreQ.delete();  // in-flight work is discarded
        @(posedge clk);
        #1;
        rst = 1'b0;
        idleCycles(6);  // monitor flags any leftover outValid
        for (int i = 0; i < 20; i++) begin
            issueOp(mulTypesPkg::operand_t'($urandom()), mulTypesPkg::operand_t'($urandom()),
                    1'($urandom()));
        end
        idleCycles(1);
        waitDrain();
    endtask

    initial begin
        rst            = 1'b1;
        inValid        = 1'b0;
        opA            = '0;
        opB            = '0;
        isSigned       = 1'b0;
        cycleCount     = 0;
        valueErrors    = 0;
        latencyErrors  = 0;
        protocolErrors = 0;
        void'($urandom(99));

        resetState();
        signedCorners();
        unsignedCorners();
        backToBack();
        gappedStream();
        midStreamReset();
        idleCycles(4);

        if (scoreQ.size() != 0) begin
            protocolErrors++;
            $display("scoreboard not empty at end of run: %0d entries left", scoreQ.size());
        end

        $display("errors: %0d value, %0d latency, %0d protocol",
                 valueErrors, latencyErrors, protocolErrors);
        if (valueErrors + latencyErrors + protocolErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== mulBooth.f ====
src/mulTypesPkg.sv
src/boothPkg.sv
src/boothEncoder.sv
src/csaReduce.sv
src/finalAdder.sv
src/boothMulPipe.sv
tests/tbBoothMul.sv
